/* filelist.f */
hdl/read_cmd_pkg.sv
hdl/read_cmd_steer.sv
hdl/read_cmd_queue.sv
hdl/read_cmd_arbiter.sv
hdl/read_cmd_control.sv
verif/read_cmd_control_chk.sv
verif/tb_read_cmd_control.sv

/* hdl/read_cmd_arbiter.sv */
`timescale 1ns/1ns

module read_cmd_arbiter (
	input  logic                       clock         ,
	input  logic                       rstn_internal ,
	input  logic                       enable_level  ,
	input  logic                       buffer_alfull ,
	input  logic                       job_not_empty ,
	input  logic                       edge_not_empty,
	input  read_cmd_pkg::address_t     job_address   ,
	input  read_cmd_pkg::address_t     edge_address  ,
	input  read_cmd_pkg::cmd_tag_t     job_tag       ,
	input  read_cmd_pkg::cmd_tag_t     edge_tag      ,
	output logic                       job_pop       ,
	output logic                       edge_pop      ,
	output logic                       out_valid     ,
	output read_cmd_pkg::array_class_t out_class     ,
	output read_cmd_pkg::address_t     out_address   ,
	output read_cmd_pkg::cmd_tag_t     out_tag
);

	import read_cmd_pkg::*;

	logic         enable_q    ;
	logic         alfull_q    ;
	logic         job_grant   ;
	logic         edge_grant  ;
	logic         pop_pending ;
	logic         job_request ;
	logic         edge_request;
	logic         job_win     ;
	logic         edge_win    ;
	array_class_t last_class  ;

////////////////////////////////////////////////////////////////////////
// Enable and back-pressure sampling
////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			enable_q <= 1'b0;
			alfull_q <= 1'b0;
		end else begin
			enable_q <= enable_level;
			alfull_q <= buffer_alfull;
		end
	end

////////////////////////////////////////////////////////////////////////
// Round-robin grant
////////////////////////////////////////////////////////////////////////

	// A registered grant pops its queue in the following cycle,
	// so the heads are stale until that pop lands
	assign pop_pending = job_grant | edge_grant;

	assign job_request  = job_not_empty & enable_q & ~alfull_q & ~pop_pending;
	assign edge_request = edge_not_empty & enable_q & ~alfull_q & ~pop_pending;

	// Tie goes to the class that lost last time
	assign job_win  = job_request & (~edge_request | (last_class == CLASS_EDGE_DATA));
	assign edge_win = edge_request & ~job_win;

	// Edge-data counts as last granted, so vertex-job goes first
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			job_grant  <= 1'b0;
			edge_grant <= 1'b0;
			last_class <= CLASS_EDGE_DATA;
		end else begin
			job_grant  <= job_win;
			edge_grant <= edge_win;
			if (job_win) begin
				last_class <= CLASS_VERTEX_JOB;
			end else if (edge_win) begin
				last_class <= CLASS_EDGE_DATA;
			end
		end
	end

	assign job_pop  = job_grant;
	assign edge_pop = edge_grant;

////////////////////////////////////////////////////////////////////////
// Output register
////////////////////////////////////////////////////////////////////////

	// Not gated by enable, a granted command always comes out
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop_pending;
		end
	end

	always_ff @(posedge clock) begin
		if (pop_pending) begin
			if (edge_grant) begin
				out_class   <= CLASS_EDGE_DATA;
				out_address <= edge_address;
				out_tag     <= edge_tag;
			end else begin
				out_class   <= CLASS_VERTEX_JOB;
				out_address <= job_address;
				out_tag     <= job_tag;
			end
		end
	end

endmodule

/* hdl/read_cmd_control.sv */
`timescale 1ns/1ns

module read_cmd_control (
	input  logic                       clock        ,
	input  logic                       rstn_internal,
	input  logic                       in_valid     ,
	input  read_cmd_pkg::array_class_t in_class     ,
	input  read_cmd_pkg::address_t     in_address   ,
	input  read_cmd_pkg::cmd_tag_t     in_tag       ,
	input  logic                       enable_level ,
	input  logic                       buffer_alfull,
	output logic                       out_valid    ,
	output read_cmd_pkg::array_class_t out_class    ,
	output read_cmd_pkg::address_t     out_address  ,
	output read_cmd_pkg::cmd_tag_t     out_tag
);

	import read_cmd_pkg::*;

	// Steer to queues
	logic     job_push     ;
	logic     edge_push    ;
	address_t steer_address;
	cmd_tag_t steer_tag    ;

	// Queues to arbiter
	logic     job_pop         ;
	logic     edge_pop        ;
	logic     job_not_empty   ;
	logic     edge_not_empty  ;
	address_t job_head_address ;
	address_t edge_head_address;
	cmd_tag_t job_head_tag     ;
	cmd_tag_t edge_head_tag    ;

////////////////////////////////////////////////////////////////////////
// Input register and class steering
////////////////////////////////////////////////////////////////////////

	read_cmd_steer i_steer (
		.clock        (clock        ),
		.rstn_internal(rstn_internal),
		.in_valid     (in_valid     ),
		.in_class     (in_class     ),
		.in_address   (in_address   ),
		.in_tag       (in_tag       ),
		.job_push     (job_push     ),
		.edge_push    (edge_push    ),
		.steer_address(steer_address),
		.steer_tag    (steer_tag    )
	);

////////////////////////////////////////////////////////////////////////
// Per-class queues
////////////////////////////////////////////////////////////////////////

	read_cmd_queue i_job_queue (
		.clock        (clock           ),
		.rstn_internal(rstn_internal   ),
		.push         (job_push        ),
		.pop          (job_pop         ),
		.push_address (steer_address   ),
		.push_tag     (steer_tag       ),
		.not_empty    (job_not_empty   ),
		.head_address (job_head_address),
		.head_tag     (job_head_tag    )
	);

	// Edge data goes straight in, no cache lookup in front
	read_cmd_queue i_edge_queue (
		.clock        (clock            ),
		.rstn_internal(rstn_internal    ),
		.push         (edge_push        ),
		.pop          (edge_pop         ),
		.push_address (steer_address    ),
		.push_tag     (steer_tag        ),
		.not_empty    (edge_not_empty   ),
		.head_address (edge_head_address),
		.head_tag     (edge_head_tag    )
	);

////////////////////////////////////////////////////////////////////////
// Merge onto the read command output
////////////////////////////////////////////////////////////////////////

	read_cmd_arbiter i_arbiter (
		.clock         (clock            ),
		.rstn_internal (rstn_internal    ),
		.enable_level  (enable_level     ),
		.buffer_alfull (buffer_alfull    ),
		.job_not_empty (job_not_empty    ),
		.edge_not_empty(edge_not_empty   ),
		.job_address   (job_head_address ),
		.edge_address  (edge_head_address),
		.job_tag       (job_head_tag     ),
		.edge_tag      (edge_head_tag    ),
		.job_pop       (job_pop          ),
		.edge_pop      (edge_pop         ),
		.out_valid     (out_valid        ),
		.out_class     (out_class        ),
		.out_address   (out_address      ),
		.out_tag       (out_tag          )
	);

endmodule

/* hdl/read_cmd_pkg.sv */
package read_cmd_pkg;

////////////////////////////////////////////////////////////////////////
// Command fields
////////////////////////////////////////////////////////////////////////

	// Byte address of a read
	typedef logic [31:0] address_t;

	// Request id, returned with the data
	typedef logic [7:0] cmd_tag_t;

	// Target graph array
	typedef logic [0:0] array_class_t;

	localparam array_class_t CLASS_VERTEX_JOB = 1'b0;
	localparam array_class_t CLASS_EDGE_DATA  = 1'b1;

////////////////////////////////////////////////////////////////////////
// Class queues
////////////////////////////////////////////////////////////////////////

	// Entries per queue, kept a power of two
	localparam int QUEUE_DEPTH = 16;

	// Holds 0 up to QUEUE_DEPTH inclusive
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count_t;

endpackage

/* hdl/read_cmd_queue.sv */
`timescale 1ns/1ns

module read_cmd_queue (
	input  logic                   clock        ,
	input  logic                   rstn_internal,
	input  logic                   push         ,
	input  logic                   pop          ,
	input  read_cmd_pkg::address_t push_address ,
	input  read_cmd_pkg::cmd_tag_t push_tag     ,
	output logic                   not_empty    ,
	output read_cmd_pkg::address_t head_address ,
	output read_cmd_pkg::cmd_tag_t head_tag
);

	import read_cmd_pkg::*;

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

	address_t             address_mem[0:QUEUE_DEPTH-1];
	cmd_tag_t             tag_mem    [0:QUEUE_DEPTH-1];
	logic [PTR_WIDTH-1:0] wr_ptr ;
	logic [PTR_WIDTH-1:0] rd_ptr ;
	queue_count_t         count  ;
	logic                 full   ;
	logic                 do_push;
	logic                 do_pop ;

////////////////////////////////////////////////////////////////////////
// Status
////////////////////////////////////////////////////////////////////////

	assign not_empty = (count != '0);
	assign full      = (count == queue_count_t'(QUEUE_DEPTH));

	// Ignore pop on empty and push on full
	assign do_pop  = pop & not_empty;
	assign do_push = push & ~full;

////////////////////////////////////////////////////////////////////////
// Pointers and occupancy
////////////////////////////////////////////////////////////////////////

	// Depth is a power of two, pointers wrap by themselves
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

////////////////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			address_mem[wr_ptr] <= push_address;
			tag_mem[wr_ptr]     <= push_tag;
		end
	end

	// Head is meaningful only while not_empty
	assign head_address = address_mem[rd_ptr];
	assign head_tag     = tag_mem[rd_ptr];

endmodule

/* hdl/read_cmd_steer.sv */
`timescale 1ns/1ns

module read_cmd_steer (
	input  logic                       clock        ,
	input  logic                       rstn_internal,
	input  logic                       in_valid     ,
	input  read_cmd_pkg::array_class_t in_class     ,
	input  read_cmd_pkg::address_t     in_address   ,
	input  read_cmd_pkg::cmd_tag_t     in_tag       ,
	output logic                       job_push     ,
	output logic                       edge_push    ,
	output read_cmd_pkg::address_t     steer_address,
	output read_cmd_pkg::cmd_tag_t     steer_tag
);

	import read_cmd_pkg::*;

	logic         in_valid_q  ;
	array_class_t in_class_q  ;
	address_t     in_address_q;
	cmd_tag_t     in_tag_q    ;

////////////////////////////////////////////////////////////////////////
// Input register
////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= in_valid;
		end
	end

	// Only load on a real command, saves toggling on idle cycles
	always_ff @(posedge clock) begin
		if (in_valid) begin
			in_class_q   <= in_class;
			in_address_q <= in_address;
			in_tag_q     <= in_tag;
		end
	end

////////////////////////////////////////////////////////////////////////
// Class demux
////////////////////////////////////////////////////////////////////////

	// One strobe per class, at most one high
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (~rstn_internal) begin
			job_push  <= 1'b0;
			edge_push <= 1'b0;
		end else begin
			job_push  <= in_valid_q & (in_class_q == CLASS_VERTEX_JOB);
			edge_push <= in_valid_q & (in_class_q == CLASS_EDGE_DATA);
		end
	end

	// Address and tag are shared by both queues
	always_ff @(posedge clock) begin
		if (in_valid_q) begin
			steer_address <= in_address_q;
			steer_tag     <= in_tag_q;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/bash
# Build and run the read command testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f filelist.f \
	--top-module tb_read_cmd_control -o sim_read_cmd && \
	./obj_dir/sim_read_cmd | tee /dev/stderr | \
	grep -q "Simulation finished: PASS" && \
	echo "Run passed" || \
	{ echo "Run failed"; exit 1; }

/* verif/read_cmd_control_chk.sv */
`timescale 1ns/1ns

module read_cmd_control_chk (
	input logic                       clock        ,
	input logic                       rstn_internal,
	input logic                       enable_level ,
	input logic                       buffer_alfull,
	input logic                       out_valid    ,
	input read_cmd_pkg::array_class_t out_class
);

	// Nothing leaves the unit while reset is held
	assert property (@(posedge clock) !rstn_internal |-> !out_valid)
		else $error("out_valid high during reset");

	// Grant already in flight may still land, after that the output is quiet
	assert property (@(posedge clock) disable iff (!rstn_internal)
		(buffer_alfull && $past(buffer_alfull) && $past(buffer_alfull, 2) &&
		$past(buffer_alfull, 3)) |-> !out_valid)
		else $error("out_valid high while buffer_alfull held");

	assert property (@(posedge clock) disable iff (!rstn_internal)
		(!enable_level && !$past(enable_level) && !$past(enable_level, 2) &&
		!$past(enable_level, 3)) |-> !out_valid)
		else $error("out_valid high while enable_level low");

	assert property (@(posedge clock) disable iff (!rstn_internal)
		out_valid |-> !$isunknown(out_class))
		else $error("out_class unknown with out_valid high");

endmodule

bind read_cmd_control read_cmd_control_chk i_chk (
	.clock        (clock        ),
	.rstn_internal(rstn_internal),
	.enable_level (enable_level ),
	.buffer_alfull(buffer_alfull),
	.out_valid    (out_valid    ),
	.out_class    (out_class    )
);

/* verif/read_cmd_stimulus.txt */
# Records: test <name> | cmd <class> <address> <tag> | expect <class> <address> <tag>
# idle <cycles> | stall <0|1> | enable <0|1> | wait (until all expected outputs seen)
test single
expect 0 00001000 11
expect 1 20002000 22
cmd 0 00001000 11
idle 10
cmd 1 20002000 22
wait
test order
expect 0 00001100 31
expect 1 20002100 33
expect 0 00001104 32
expect 1 20002104 34
cmd 0 00001100 31
cmd 0 00001104 32
cmd 1 20002100 33
cmd 1 20002104 34
wait
test stall
expect 0 00001200 41
expect 1 20002200 43
expect 0 00001204 42
stall 1
cmd 0 00001200 41
cmd 0 00001204 42
cmd 1 20002200 43
idle 12
stall 0
wait
test round_robin
expect 1 20002300 57
expect 0 00001300 51
expect 1 20002304 58
expect 0 00001304 52
expect 1 20002308 59
expect 0 00001308 53
expect 0 0000130c 54
expect 0 00001310 55
expect 0 00001314 56
stall 1
cmd 0 00001300 51
cmd 0 00001304 52
cmd 0 00001308 53
cmd 0 0000130c 54
cmd 0 00001310 55
cmd 0 00001314 56
cmd 1 20002300 57
cmd 1 20002304 58
cmd 1 20002308 59
idle 12
stall 0
wait
test enable
expect 1 20002400 62
expect 0 00001400 61
expect 1 20002404 63
enable 0
cmd 0 00001400 61
cmd 1 20002400 62
cmd 1 20002404 63
idle 12
enable 1
wait
idle 20

/* verif/tb_read_cmd_control.sv */
`timescale 1ns/1ns

module tb_read_cmd_control;

	import read_cmd_pkg::*;

	localparam string STIMULUS_FILE = "verif/read_cmd_stimulus.txt";

	logic         clock        ;
	logic         rstn_internal;
	logic         in_valid     ;
	array_class_t in_class     ;
	address_t     in_address   ;
	cmd_tag_t     in_tag       ;
	logic         enable_level ;
	logic         buffer_alfull;
	logic         out_valid    ;
	array_class_t out_class    ;
	address_t     out_address  ;
	cmd_tag_t     out_tag      ;

	// Expected outputs in order, one entry per command
	array_class_t exp_class_q  [$];
	address_t     exp_address_q[$];
	cmd_tag_t     exp_tag_q    [$];
	string        exp_name_q   [$];

	int    value_errors    ;
	int    sequence_errors ;
	int    cycle_count     ;
	int    cycle_limit     ;
	int    alfull_run      ;
	int    disabled_run    ;
	string test_name       ;

	read_cmd_control i_dut (
		.clock        (clock        ),
		.rstn_internal(rstn_internal),
		.in_valid     (in_valid     ),
		.in_class     (in_class     ),
		.in_address   (in_address   ),
		.in_tag       (in_tag       ),
		.enable_level (enable_level ),
		.buffer_alfull(buffer_alfull),
		.out_valid    (out_valid    ),
		.out_class    (out_class    ),
		.out_address  (out_address  ),
		.out_tag      (out_tag      )
	);

	always #20 clock = ~clock;

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

	task automatic check_address(string name, address_t expected, address_t actual);
		if (expected !== actual) begin
			value_errors++;
			$display("FAIL %s address expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_tag(string name, array_class_t exp_cls, cmd_tag_t expected,
		array_class_t act_cls, cmd_tag_t actual);
		if (exp_cls !== act_cls || expected !== actual) begin
			value_errors++;
			$display("FAIL %s class/tag expected %h/%h actual %h/%h",
				name, exp_cls, expected, act_cls, actual);
		end
	endtask

//////////////////////////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////////////////////////

	task automatic drive_command(array_class_t cls, address_t addr, cmd_tag_t tag);
		@(posedge clock);
		in_valid   <= 1'b1;
		in_class   <= cls;
		in_address <= addr;
		in_tag     <= tag;
	endtask

	task automatic idle_cycles(int cycles);
		repeat (cycles) begin
			@(posedge clock);
			in_valid <= 1'b0;
		end
	endtask

	// Drains until every expected output has been seen
	task automatic wait_for_drain();
		do begin
			@(posedge clock);
			in_valid <= 1'b0;
		end while (exp_tag_q.size() != 0);
	endtask

//////////////////////////////////////////////////////////////////////
// Output monitor and timeout
//////////////////////////////////////////////////////////////////////

	// Sampled mid-cycle, away from the driving edge
	always @(negedge clock) begin
		if (rstn_internal) begin
			alfull_run   = buffer_alfull ? alfull_run + 1 : 0;
			disabled_run = enable_level ? 0 : disabled_run + 1;
			if (out_valid) begin
				if (alfull_run >= 4 || disabled_run >= 4) begin
					sequence_errors++;
					$display("Output tag %h appeared while stalled or disabled", out_tag);
				end
				if (exp_tag_q.size() == 0) begin
					sequence_errors++;
					$display("Output tag %h appeared with no command expected", out_tag);
				end else begin
					check_address(exp_name_q[0], exp_address_q[0], out_address);
					check_tag(exp_name_q[0], exp_class_q[0], exp_tag_q[0], out_class, out_tag);
					void'(exp_class_q.pop_front());
					void'(exp_address_q.pop_front());
					void'(exp_tag_q.pop_front());
					void'(exp_name_q.pop_front());
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, outputs still missing", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

//////////////////////////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////////////////////////

	initial begin
		integer       fd;
		integer       status;
		int           records;
		int           value;
		string        word;
		string        line;
		array_class_t cls;
		address_t     addr;
		cmd_tag_t     tag;

		clock           = 1'b0;
		rstn_internal   = 1'b0;
		in_valid        = 1'b0;
		in_class        = CLASS_VERTEX_JOB;
		in_address      = '0;
		in_tag          = '0;
		enable_level    = 1'b1;
		buffer_alfull   = 1'b0;
		value_errors    = 0;
		sequence_errors = 0;
		cycle_count     = 0;
		alfull_run      = 0;
		disabled_run    = 0;
		records         = 0;
		test_name       = "none";
		cycle_limit     = 200;

		fd = $fopen(STIMULUS_FILE, "r");
		if (fd != 0) begin
			// First pass counts records for the cycle limit
			while (!$feof(fd)) begin
				status = $fgets(line, fd);
				if (status > 1 && line.getc(0) != "#") begin
					records++;
				end
			end
			$fclose(fd);
			cycle_limit = 40 * records + 200;
			fd = $fopen(STIMULUS_FILE, "r");

			repeat (16) @(posedge clock);
			rstn_internal <= 1'b1;

			while ($fscanf(fd, "%s", word) == 1) begin
				if (word.getc(0) == "#") begin
					status = $fgets(line, fd);
				end else if (word == "test") begin
					status = $fscanf(fd, "%s", test_name);
				end else if (word == "expect") begin
					status = $fscanf(fd, "%h %h %h", cls, addr, tag);
					exp_class_q.push_back(cls);
					exp_address_q.push_back(addr);
					exp_tag_q.push_back(tag);
					exp_name_q.push_back(test_name);
				end else if (word == "cmd") begin
					status = $fscanf(fd, "%h %h %h", cls, addr, tag);
					drive_command(cls, addr, tag);
				end else if (word == "idle") begin
					status = $fscanf(fd, "%d", value);
					idle_cycles(value);
				end else if (word == "stall") begin
					status = $fscanf(fd, "%d", value);
					@(posedge clock);
					in_valid      <= 1'b0;
					buffer_alfull <= (value != 0);
				end else if (word == "enable") begin
					status = $fscanf(fd, "%d", value);
					@(posedge clock);
					in_valid     <= 1'b0;
					enable_level <= (value != 0);
				end else if (word == "wait") begin
					wait_for_drain();
				end else begin
					sequence_errors++;
					$display("Unknown stimulus record %s", word);
				end
			end
			$fclose(fd);
		end else begin
			sequence_errors++;
			$display("Could not open stimulus file %s", STIMULUS_FILE);
		end

		if (exp_tag_q.size() != 0) begin
			sequence_errors += exp_tag_q.size();
			$display("%0d expected commands never appeared", exp_tag_q.size());
		end

		$display("Error counts: %0d value, %0d sequence", value_errors, sequence_errors);
		if (value_errors == 0 && sequence_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
